// ==== rtl/gnn_pkg.sv ====
`default_nettype none

package gnn_pkg;

    localparam int NODE_W    = 6;                      // 64 nodes
    localparam int ADDR_W    = 8;
    localparam int FEAT_W    = 8;
    localparam int SUM_W     = 12;                     // 9 terms of 255
    localparam int MAX_DEG   = 8;
    localparam int ADJ_BASE  = 64;                     // header of node n at ADJ_BASE + n
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int DEG_W     = $clog2(MAX_DEG + 1);
    localparam int WCNT_W    = $clog2(MAX_DEG / 2 + 1); // edge words walked by one lane
    localparam int ID_W      = 8;                      // stored id field, low NODE_W bits used

    localparam int PE_STATE_W = 3;
    localparam logic [PE_STATE_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [PE_STATE_W-1:0] ST_HEADER  = 3'd1;
    localparam logic [PE_STATE_W-1:0] ST_EDGE    = 3'd2;
    localparam logic [PE_STATE_W-1:0] ST_FEATURE = 3'd3;
    localparam logic [PE_STATE_W-1:0] ST_SELF    = 3'd4;
    localparam logic [PE_STATE_W-1:0] ST_FINISH  = 3'd5;

    typedef logic [NODE_W-1:0] node_t;
    typedef logic [SUM_W-1:0]  sum_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // one 16 bit memory word, meaning depends on the address region
    typedef union packed {
        struct packed {
            logic [FEAT_W-1:0] f1;
            logic [FEAT_W-1:0] f0;
        } feat;
        struct packed {
            logic [DEG_W-1:0] deg;
            logic [DEG_W-1:0] pad;
            addr_t            base;
        } hdr;
        struct packed {
            logic [ID_W-1:0] id1;
            logic [ID_W-1:0] id0;
        } edges;                                       // neighbors 2k+1 and 2k
    } mem_word_t;

endpackage

`default_nettype wire

// ==== rtl/wb_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_rd_if ();

    logic               cyc;
    logic               stb;
    gnn_pkg::addr_t     adr;
    gnn_pkg::mem_word_t dat_r;
    logic               ack;                           // one cycle, dat_r valid with it

    modport master (
        output cyc,
        output stb,
        output adr,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  adr,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// ==== rtl/lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lane_if ();

    logic           start;                             // one cycle pulse
    gnn_pkg::node_t node;
    logic           self_loop;
    logic           done;                              // one cycle pulse
    gnn_pkg::sum_t  sum0;                              // valid from done to next start
    gnn_pkg::sum_t  sum1;

    modport aggr (
        output start,
        output node,
        output self_loop,
        input  done,
        input  sum0,
        input  sum1
    );

    modport pe (
        input  start,
        input  node,
        input  self_loop,
        output done,
        output sum0,
        output sum1
    );

endinterface

`default_nettype wire

// ==== rtl/edge_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_pe #(
    parameter int LANE = 0
) (
    input  wire logic clk,
    input  wire logic reset,
    lane_if.pe        ctl,
    wb_rd_if.master   bus
);

    logic [gnn_pkg::PE_STATE_W-1:0] state;
    gnn_pkg::node_t                 node_q;
    logic                           self_q;
    logic [gnn_pkg::DEG_W-1:0]      deg;
    gnn_pkg::addr_t                 ebase;
    logic [gnn_pkg::WCNT_W-1:0]     word_cnt;
    gnn_pkg::sum_t                  sum0;
    gnn_pkg::sum_t                  sum1;
    logic [gnn_pkg::ID_W-1:0]       lane_id;
    logic [gnn_pkg::DEG_W-1:0]      next_idx;
    logic                           want_self;
    gnn_pkg::sum_t                  feat0;
    gnn_pkg::sum_t                  feat1;

    // edge word k holds neighbors 2k and 2k+1, this lane owns 2k+LANE
    assign next_idx  = {word_cnt, 1'(LANE)};
    assign lane_id   = (LANE == 1) ? bus.dat_r.edges.id1 : bus.dat_r.edges.id0;
    assign want_self = (LANE == 0) && self_q;          // self loop handled by lane 0 only
    assign feat0     = gnn_pkg::sum_t'(bus.dat_r.feat.f0);
    assign feat1     = gnn_pkg::sum_t'(bus.dat_r.feat.f1);

    assign ctl.done = (state == gnn_pkg::ST_FINISH);
    assign ctl.sum0 = sum0;
    assign ctl.sum1 = sum1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= gnn_pkg::ST_IDLE;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
        end else begin
            case (state)
                gnn_pkg::ST_IDLE: begin
                    if (ctl.start) begin
                        node_q   <= ctl.node;
                        self_q   <= ctl.self_loop;
                        word_cnt <= '0;
                        sum0     <= '0;
                        sum1     <= '0;
                        bus.adr  <= gnn_pkg::addr_t'(gnn_pkg::ADJ_BASE)
                                    + gnn_pkg::addr_t'(ctl.node);
                        bus.cyc  <= 1'b1;
                        bus.stb  <= 1'b1;
                        state    <= gnn_pkg::ST_HEADER;
                    end
                end
                gnn_pkg::ST_HEADER: begin
                    if (bus.ack) begin
                        deg   <= bus.dat_r.hdr.deg;
                        ebase <= bus.dat_r.hdr.base;
                        if (next_idx < bus.dat_r.hdr.deg) begin
                            bus.adr <= bus.dat_r.hdr.base; // first edge word
                            state   <= gnn_pkg::ST_EDGE;
                        end else if (want_self) begin
                            bus.adr <= gnn_pkg::addr_t'(node_q);
                            state   <= gnn_pkg::ST_SELF;
                        end else begin
                            bus.cyc <= 1'b0;
                            bus.stb <= 1'b0;
                            state   <= gnn_pkg::ST_FINISH;
                        end
                    end
                end
                gnn_pkg::ST_EDGE: begin
                    if (bus.ack) begin
                        bus.adr  <= gnn_pkg::addr_t'(lane_id[gnn_pkg::NODE_W-1:0]);
                        word_cnt <= word_cnt + 1'b1;
                        state    <= gnn_pkg::ST_FEATURE;
                    end
                end
                gnn_pkg::ST_FEATURE: begin
                    if (bus.ack) begin
                        sum0 <= sum0 + feat0;
                        sum1 <= sum1 + feat1;
                        if (next_idx < deg) begin
                            bus.adr <= ebase + gnn_pkg::addr_t'(word_cnt);
                            state   <= gnn_pkg::ST_EDGE;
                        end else if (want_self) begin
                            bus.adr <= gnn_pkg::addr_t'(node_q);
                            state   <= gnn_pkg::ST_SELF;
                        end else begin
                            bus.cyc <= 1'b0;
                            bus.stb <= 1'b0;
                            state   <= gnn_pkg::ST_FINISH;
                        end
                    end
                end
                gnn_pkg::ST_SELF: begin
                    if (bus.ack) begin
                        sum0    <= sum0 + feat0;
                        sum1    <= sum1 + feat1;
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        state   <= gnn_pkg::ST_FINISH;
                    end
                end
                gnn_pkg::ST_FINISH: begin
                    state <= gnn_pkg::ST_IDLE;         // done pulses here
                end
                default: begin
                    bus.cyc <= 1'b0;
                    bus.stb <= 1'b0;
                    state   <= gnn_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/graph_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module graph_mem_arbiter (
    input  wire logic clk,
    input  wire logic reset,
    wb_rd_if.slave    m0,
    wb_rd_if.slave    m1,
    wb_rd_if.master   s
);

    logic req0;
    logic req1;
    logic locked;                                      // grant held until ack
    logic owner;
    logic prio;                                        // preferred lane on a tie
    logic sel;

    assign req0 = m0.cyc && m0.stb;
    assign req1 = m1.cyc && m1.stb;

    always_comb begin
        if (locked) begin
            sel = owner;
        end else if (req0 && req1) begin
            sel = prio;
        end else begin
            sel = req1;
        end
    end

    assign s.cyc = sel ? m1.cyc : m0.cyc;
    assign s.stb = sel ? m1.stb : m0.stb;
    assign s.adr = sel ? m1.adr : m0.adr;

    assign m0.ack   = s.ack && !sel;
    assign m1.ack   = s.ack && sel;
    assign m0.dat_r = sel ? '0 : s.dat_r;
    assign m1.dat_r = sel ? s.dat_r : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
            owner  <= 1'b0;
            prio   <= 1'b0;
        end else if (locked && s.ack) begin
            locked <= 1'b0;
            prio   <= !owner;                          // other lane goes first next
        end else if (!locked && s.cyc && s.stb) begin
            locked <= 1'b1;
            owner  <= sel;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/graph_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module graph_mem (
    input  wire logic               clk,
    input  wire logic               reset,
    wb_rd_if.slave                  bus,
    input  wire logic               mem_we,
    input  wire gnn_pkg::addr_t     mem_addr,
    input  wire gnn_pkg::mem_word_t mem_wdata
);

    gnn_pkg::mem_word_t mem [gnn_pkg::MEM_WORDS];

    // features at 0..63, headers from ADJ_BASE, edge lists anywhere
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;                // preload only
        end
        bus.dat_r <= mem[bus.adr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc && bus.stb && !bus.ack; // single cycle ack
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aggr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aggr_unit (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           task_valid,
    input  wire gnn_pkg::node_t task_node,
    input  wire logic           task_self,
    output logic                task_ready,
    input  wire logic           res_ready,
    output logic                res_valid,
    output gnn_pkg::node_t      res_node,
    output gnn_pkg::sum_t       res_sum0,
    output gnn_pkg::sum_t       res_sum1,
    lane_if.aggr                l0,
    lane_if.aggr                l1
);

    logic           busy;                              // task accepted, result not taken
    logic           accept;
    logic           start_q;
    logic           got0;
    logic           got1;
    logic           both_in;
    gnn_pkg::node_t node_q;
    logic           self_q;

    assign task_ready = !busy;
    assign accept     = task_valid && task_ready;
    assign both_in    = (got0 || l0.done) && (got1 || l1.done);

    assign l0.start     = start_q;
    assign l0.node      = node_q;
    assign l0.self_loop = self_q;
    assign l1.start     = start_q;
    assign l1.node      = node_q;
    assign l1.self_loop = self_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            start_q   <= 1'b0;
            got0      <= 1'b0;
            got1      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                busy   <= 1'b1;
                node_q <= task_node;
                self_q <= task_self;
            end
            if (both_in) begin
                got0      <= 1'b0;
                got1      <= 1'b0;
                res_valid <= 1'b1;
                res_node  <= node_q;
                res_sum0  <= l0.sum0 + l1.sum0;
                res_sum1  <= l0.sum1 + l1.sum1;
            end else begin
                got0 <= got0 || l0.done;
                got1 <= got1 || l1.done;
            end
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gnn_edge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_edge_top (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               task_valid,
    input  wire gnn_pkg::node_t     task_node,
    input  wire logic               task_self,
    output logic                    task_ready,
    input  wire logic               res_ready,
    output logic                    res_valid,
    output gnn_pkg::node_t          res_node,
    output gnn_pkg::sum_t           res_sum0,
    output gnn_pkg::sum_t           res_sum1,
    input  wire logic               mem_we,
    input  wire gnn_pkg::addr_t     mem_addr,
    input  wire gnn_pkg::mem_word_t mem_wdata
);

    lane_if  lane0_if ();
    lane_if  lane1_if ();
    wb_rd_if pe0_bus ();
    wb_rd_if pe1_bus ();
    wb_rd_if mem_bus ();

    aggr_unit aggr_unit_i (
        .clk        (clk),
        .reset      (reset),
        .task_valid (task_valid),
        .task_node  (task_node),
        .task_self  (task_self),
        .task_ready (task_ready),
        .res_ready  (res_ready),
        .res_valid  (res_valid),
        .res_node   (res_node),
        .res_sum0   (res_sum0),
        .res_sum1   (res_sum1),
        .l0         (lane0_if.aggr),
        .l1         (lane1_if.aggr)
    );

    edge_pe #(.LANE(0)) edge_pe_0 (
        .clk   (clk),
        .reset (reset),
        .ctl   (lane0_if.pe),
        .bus   (pe0_bus.master)
    );

    edge_pe #(.LANE(1)) edge_pe_1 (
        .clk   (clk),
        .reset (reset),
        .ctl   (lane1_if.pe),
        .bus   (pe1_bus.master)
    );

    graph_mem_arbiter arbiter_i (
        .clk   (clk),
        .reset (reset),
        .m0    (pe0_bus.slave),
        .m1    (pe1_bus.slave),
        .s     (mem_bus.master)
    );

    graph_mem graph_mem_i (
        .clk       (clk),
        .reset     (reset),
        .bus       (mem_bus.slave),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/gnn_edge_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_edge_sva (
    input wire logic           clk,
    input wire logic           reset,
    input wire logic           cyc,
    input wire logic           stb,
    input wire gnn_pkg::addr_t adr,
    input wire logic           ack,
    input wire logic           task_ready,
    input wire logic           res_ready,
    input wire logic           res_valid,
    input wire gnn_pkg::node_t res_node,
    input wire gnn_pkg::sum_t  res_sum0,
    input wire gnn_pkg::sum_t  res_sum1
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
        else $error("ack seen without cyc and stb");

    adr_held: assert property (@(posedge clk) disable iff (reset)
        cyc && stb && !ack |=> $stable(adr))                          // memory side of arbiter
        else $error("adr changed before ack");

    res_held: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable({res_node, res_sum0, res_sum1}))
        else $error("result changed under back-pressure");

    busy_while_valid: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> !task_ready)
        else $error("task_ready high while a result waits");

endmodule

bind gnn_edge_top gnn_edge_sva gnn_edge_sva_i (
    .*,
    .cyc (mem_bus.cyc),
    .stb (mem_bus.stb),
    .adr (mem_bus.adr),
    .ack (mem_bus.ack)
);

`default_nettype wire

// ==== tb/gnn_edge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_edge_tb;

    localparam int TIMEOUT   = 2000;
    localparam int ROUNDS    = 6;
    localparam int NODES     = 1 << gnn_pkg::NODE_W;
    localparam int EDGE_BASE = gnn_pkg::ADJ_BASE + NODES;             // edge words after headers
    localparam int BASE_SPAN = gnn_pkg::MEM_WORDS - gnn_pkg::MAX_DEG / 2 - EDGE_BASE + 1;

    logic               clk;
    logic               reset;
    logic               task_valid;
    gnn_pkg::node_t     task_node;
    logic               task_self;
    logic               task_ready;
    logic               res_ready;
    logic               res_valid;
    gnn_pkg::node_t     res_node;
    gnn_pkg::sum_t      res_sum0;
    gnn_pkg::sum_t      res_sum1;
    logic               mem_we;
    gnn_pkg::addr_t     mem_addr;
    gnn_pkg::mem_word_t mem_wdata;
    gnn_pkg::mem_word_t model [gnn_pkg::MEM_WORDS];                   // mirror of graph memory
    logic [15:0]        lfsr_state;

    gnn_edge_top gnn_edge_top_i (.*);

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        repeat (n) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run("handshake flag mismatch");
        end
    endtask

    task automatic check_result(input gnn_pkg::node_t got_node, input gnn_pkg::sum_t got0,
                                input gnn_pkg::sum_t got1, input gnn_pkg::node_t exp_node,
                                input gnn_pkg::sum_t exp0, input gnn_pkg::sum_t exp1);
        if (got_node !== exp_node || got0 !== exp0 || got1 !== exp1) begin
            $display("Fail at %0t: node %0d sums %0d %0d, expected node %0d sums %0d %0d",
                     $time, got_node, got0, got1, exp_node, exp0, exp1);
            abort_run("result mismatch");
        end
    endtask

    function automatic void expect_sums(input gnn_pkg::node_t n, input logic self_on,
                                        output gnn_pkg::sum_t e0, output gnn_pkg::sum_t e1);
        gnn_pkg::mem_word_t hdr;
        gnn_pkg::mem_word_t ew;
        gnn_pkg::node_t     nb;
        int                 i;
        hdr = model[gnn_pkg::addr_t'(gnn_pkg::ADJ_BASE) + gnn_pkg::addr_t'(n)];
        e0  = self_on ? gnn_pkg::sum_t'(model[gnn_pkg::addr_t'(n)].feat.f0) : '0;
        e1  = self_on ? gnn_pkg::sum_t'(model[gnn_pkg::addr_t'(n)].feat.f1) : '0;
        for (i = 0; i < int'(hdr.hdr.deg); i++) begin
            ew = model[hdr.hdr.base + gnn_pkg::addr_t'(i / 2)];      // two neighbors per word
            nb = gnn_pkg::node_t'((i % 2 == 1) ? ew.edges.id1 : ew.edges.id0);
            e0 = e0 + gnn_pkg::sum_t'(model[gnn_pkg::addr_t'(nb)].feat.f0);
            e1 = e1 + gnn_pkg::sum_t'(model[gnn_pkg::addr_t'(nb)].feat.f1);
        end
    endfunction

    task automatic load_graph(input logic feat_only);
        gnn_pkg::mem_word_t w;
        int                 a;
        int                 node_idx;
        int                 d;
        for (a = 0; a < (feat_only ? NODES : gnn_pkg::MEM_WORDS); a++) begin
            w = rand_bits(16);
            node_idx = a - gnn_pkg::ADJ_BASE;
            if (!feat_only && node_idx >= 0 && node_idx < NODES) begin
                case (node_idx)
                    0: d = 0;
                    1: d = 1;
                    2: d = gnn_pkg::MAX_DEG - 1;
                    default: d = int'(rand_bits(4)) % (gnn_pkg::MAX_DEG + 1);
                endcase
                w.hdr.deg  = d[gnn_pkg::DEG_W-1:0];
                w.hdr.pad  = '0;
                w.hdr.base = gnn_pkg::addr_t'(EDGE_BASE + int'(rand_bits(7)) % BASE_SPAN);
            end
            @(negedge clk);
            mem_we    = 1'b1;
            mem_addr  = gnn_pkg::addr_t'(a);
            mem_wdata = w;
            model[gnn_pkg::addr_t'(a)] = w;
        end
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    task automatic run_task(input gnn_pkg::node_t n, input logic self_on);
        gnn_pkg::sum_t e0;
        gnn_pkg::sum_t e1;
        int            waited;
        logic          taken;
        expect_sums(n, self_on, e0, e1);
        @(negedge clk);
        task_valid = 1'b1;
        task_node  = n;
        task_self  = self_on;
        waited     = 0;
        while (!task_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("task_ready never went high");
        end
        taken  = 1'b0;
        waited = 0;
        while (!taken) begin
            @(negedge clk);
            task_valid = 1'b0;
            waited++;
            if (waited > TIMEOUT) abort_run("no result arrived before the timeout");
            check_flag(task_ready, 1'b0, "task_ready during task");
            res_ready = (rand_bits(2) == 16'd0);                      // mostly stalled
            if (res_valid) begin
                check_result(res_node, res_sum0, res_sum1, n, e0, e1);
                taken = res_ready;
            end
        end
        @(negedge clk);
        res_ready = 1'b0;
        check_flag(res_valid, 1'b0, "res_valid after result taken");
        check_flag(task_ready, 1'b1, "task_ready after result taken");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int             t;
        gnn_pkg::node_t node;
        lfsr_state = 16'd18;
        reset      = 1'b1;
        task_valid = 1'b0;
        task_node  = '0;
        task_self  = 1'b0;
        res_ready  = 1'b0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag(task_ready, 1'b1, "task_ready after reset");
        check_flag(res_valid, 1'b0, "res_valid after reset");
        repeat (ROUNDS) begin
            load_graph(1'b0);
            for (t = 0; t < 5; t++) begin
                node = (t < 3) ? gnn_pkg::node_t'(t) : gnn_pkg::node_t'(rand_bits(gnn_pkg::NODE_W));
                run_task(node, 1'b0);
                run_task(node, 1'b1);                                 // adds own features
            end
            load_graph(1'b1);                                         // new features only
            run_task(node, 1'b1);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/gnn_pkg.sv
rtl/wb_rd_if.sv
rtl/lane_if.sv
rtl/edge_pe.sv
rtl/graph_mem_arbiter.sv
rtl/graph_mem.sv
rtl/aggr_unit.sv
rtl/gnn_edge_top.sv
tb/gnn_edge_sva.sv
tb/gnn_edge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gnn_edge_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
